// File: src/memory_defines.svh
`ifndef MEMORY_DEFINES_SVH
`define MEMORY_DEFINES_SVH

// widths of the memory bus
`define ADDR_WIDTH 64
`define DATA_WIDTH 64
`define STRB_WIDTH (`DATA_WIDTH / 8)

// number of 64-bit words held by the RAM
`define RAM_DEPTH 1024

// byte address where the RAM region starts
`define RAM_BASE 64'h0000_0000_0000_0000

// size of the RAM region in bytes
`define RAM_SIZE (`RAM_DEPTH * 8)

// the timer window holds mtime at offset 0 and mtimecmp at offset 8
`define TIMER_BASE 64'h0000_0000_0200_0000
`define TIMER_SIZE 16

`endif

// File: src/bus_pkg.sv
`include "memory_defines.svh"

package bus_pkg;

    typedef logic [`ADDR_WIDTH-1:0] addr_type; // byte address
    typedef logic [`DATA_WIDTH-1:0] data_type; // one bus word
    typedef logic [`STRB_WIDTH-1:0] strobe_type; // one enable per byte lane

    // a request with a zero strobe is a read
    typedef struct packed {
        logic mem_valid;
        addr_type mem_addr;
        data_type mem_wdata;
        strobe_type mem_wstrb;
    } mem_in_type;

    // the response arrives one clock after the request
    typedef struct packed {
        logic mem_ready;
        logic mem_error;
        data_type mem_rdata;
    } mem_out_type;

endpackage

// File: src/map_pkg.sv
package map_pkg;

    // which block answers the request in flight
    typedef enum logic [1:0] {
        target_none,
        target_ram,
        target_timer,
        target_error
    } target_type;

    // address bit 3 picks the timer register
    typedef enum logic {
        reg_mtime,
        reg_mtimecmp
    } timer_reg_type;

endpackage

// File: src/ram.sv
`timescale 1ns/1ps

`include "memory_defines.svh"

module ram
    import bus_pkg::*;
(
    input logic clock,
    input logic reset,
    input mem_in_type ram_in,
    output mem_out_type ram_out
);

    localparam int index_bits = $clog2(`RAM_DEPTH);

    data_type ram_block [0:`RAM_DEPTH-1];

    logic [index_bits-1:0] index;
    data_type rdata_q;
    logic ready_q;

    assign index = ram_in.mem_addr[index_bits+2:3]; // bits 2:0 are the byte offset

    // byte lanes are written independently, the read returns the old word
    always_ff @(posedge clock) begin
        if (ram_in.mem_valid) begin
            for (int lane = 0; lane < `STRB_WIDTH; lane++) begin
                if (ram_in.mem_wstrb[lane]) begin
                    ram_block[index][8*lane +: 8] <= ram_in.mem_wdata[8*lane +: 8];
                end
            end
            rdata_q <= ram_block[index];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= ram_in.mem_valid; // every request answers next cycle
        end
    end

    assign ram_out.mem_ready = ready_q;
    assign ram_out.mem_error = 1'b0; // the RAM never faults
    assign ram_out.mem_rdata = rdata_q;

endmodule

// File: src/machine_timer.sv
`timescale 1ns/1ps

module machine_timer
    import bus_pkg::*;
    import map_pkg::*;
(
    input logic clock,
    input logic reset,
    input mem_in_type timer_in,
    output mem_out_type timer_out,
    output logic timer_irq
);

    timer_reg_type reg_select;
    logic write_mtime;
    logic write_mtimecmp;
    data_type mtime;
    data_type mtimecmp;
    data_type rdata_q;
    logic ready_q;
    logic irq_q;

    // replaces the strobed byte lanes of a register with new data
    function automatic data_type merge_lanes(
        input data_type old_value,
        input data_type new_value,
        input strobe_type strobe
    );
        data_type result;
        result = old_value;
        for (int lane = 0; lane < $bits(strobe_type); lane++) begin
            if (strobe[lane]) begin
                result[8*lane +: 8] = new_value[8*lane +: 8];
            end
        end
        return result;
    endfunction

    assign reg_select = timer_reg_type'(timer_in.mem_addr[3]);
    assign write_mtime = timer_in.mem_valid && (reg_select == reg_mtime) &&
                         (|timer_in.mem_wstrb);
    assign write_mtimecmp = timer_in.mem_valid && (reg_select == reg_mtimecmp) &&
                            (|timer_in.mem_wstrb);

    always_ff @(posedge clock) begin
        if (reset) begin
            mtime <= '0;
            mtimecmp <= '0;
        end else begin
            if (write_mtime) begin
                mtime <= merge_lanes(mtime, timer_in.mem_wdata, timer_in.mem_wstrb);
            end else begin
                mtime <= mtime + 1'b1; // a write takes the place of the tick
            end
            if (write_mtimecmp) begin
                mtimecmp <= merge_lanes(mtimecmp, timer_in.mem_wdata, timer_in.mem_wstrb);
            end
        end
    end

    // reads see the register as it was before this edge
    always_ff @(posedge clock) begin
        if (timer_in.mem_valid) begin
            rdata_q <= (reg_select == reg_mtime) ? mtime : mtimecmp;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ready_q <= 1'b0;
            irq_q <= 1'b0;
        end else begin
            ready_q <= timer_in.mem_valid;
            irq_q <= (mtime >= mtimecmp); // level stays up until mtimecmp moves past mtime
        end
    end

    assign timer_out.mem_ready = ready_q;
    assign timer_out.mem_error = 1'b0;
    assign timer_out.mem_rdata = rdata_q;
    assign timer_irq = irq_q;

endmodule

// File: src/bus_router.sv
`timescale 1ns/1ps

`include "memory_defines.svh"

module bus_router
    import bus_pkg::*;
    import map_pkg::*;
(
    input logic clock,
    input logic reset,
    input mem_in_type bus_in,
    output mem_out_type bus_out,
    output logic timer_irq
);

    localparam addr_type ram_base = `RAM_BASE;
    localparam addr_type ram_size = `RAM_SIZE;
    localparam addr_type timer_base = `TIMER_BASE;
    localparam addr_type timer_size = `TIMER_SIZE;

    addr_type ram_offset;
    addr_type timer_offset;
    logic ram_hit;
    logic timer_hit;
    target_type next_target;
    target_type target_q;
    mem_in_type ram_in;
    mem_out_type ram_out;
    mem_in_type timer_in;
    mem_out_type timer_out;

    // offsets wrap below the base, so one unsigned compare covers the span
    assign ram_offset = bus_in.mem_addr - ram_base;
    assign timer_offset = bus_in.mem_addr - timer_base;
    assign ram_hit = ram_offset < ram_size;
    assign timer_hit = timer_offset < timer_size;

    always_comb begin
        if (!bus_in.mem_valid) begin
            next_target = target_none;
        end else if (ram_hit) begin
            next_target = target_ram;
        end else if (timer_hit) begin
            next_target = target_timer;
        end else begin
            next_target = target_error;
        end
    end

    // only the target that was hit sees a valid strobe
    always_comb begin
        ram_in = bus_in;
        ram_in.mem_valid = (next_target == target_ram);
        timer_in = bus_in;
        timer_in.mem_valid = (next_target == target_timer);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            target_q <= target_none;
        end else begin
            target_q <= next_target; // steers the response one cycle later
        end
    end

    always_comb begin
        case (target_q)
            target_ram: bus_out = ram_out;
            target_timer: bus_out = timer_out;
            target_error: bus_out = '{mem_ready: 1'b1, mem_error: 1'b1, mem_rdata: '0};
            default: bus_out = '{mem_ready: 1'b0, mem_error: 1'b0, mem_rdata: '0};
        endcase
    end

    ram ram_inst (
        .clock(clock),
        .reset(reset),
        .ram_in(ram_in),
        .ram_out(ram_out)
    );

    machine_timer timer_inst (
        .clock(clock),
        .reset(reset),
        .timer_in(timer_in),
        .timer_out(timer_out),
        .timer_irq(timer_irq)
    );

endmodule

// File: src/memory_subsystem.sv
`timescale 1ns/1ps

module memory_subsystem
    import bus_pkg::*;
(
    input logic clock,
    input logic reset,
    input mem_in_type mem_in,
    output mem_out_type mem_out,
    output logic timer_irq
);

    // the router holds the address map and both targets
    bus_router router_inst (
        .clock(clock),
        .reset(reset),
        .bus_in(mem_in),
        .bus_out(mem_out),
        .timer_irq(timer_irq)
    );

endmodule

// File: testbench/memory_subsystem_tb.sv
`timescale 1ns/1ps

`include "memory_defines.svh"

module memory_subsystem_tb
    import bus_pkg::*;
();

    localparam int random_requests = 250;
    localparam int timeout_cycles = 10 * (random_requests + 50); // ten cycles per request
    localparam addr_type ram_size = addr_type'(`RAM_SIZE);
    localparam addr_type timer_base = `TIMER_BASE;
    localparam addr_type timer_size = addr_type'(`TIMER_SIZE);

    typedef struct packed {
        data_type rdata; // expected word, or the lower bound of an mtime read
        data_type mask; // bytes of rdata the model knows
        logic error;
        logic is_mtime;
        logic rising; // must exceed the previous mtime read
    } expect_type;

    logic clock;
    logic reset;
    mem_in_type mem_in;
    mem_out_type mem_out;
    logic timer_irq;

    integer seed;
    int error_count;
    int cycle_count;
    logic awaiting_ready;
    data_type last_mtime;
    expect_type popped;
    expect_type pending [$];

    data_type ram_model [addr_type];
    data_type ram_known [addr_type];
    data_type model_mtimecmp;
    data_type mtime_floor;
    logic mtime_read;

    memory_subsystem uut (
        .clock(clock),
        .reset(reset),
        .mem_in(mem_in),
        .mem_out(mem_out),
        .timer_irq(timer_irq)
    );

    always #5 clock = ~clock;

    function automatic data_type lane_mask(input strobe_type strobe);
        data_type mask;
        mask = '0;
        for (int lane = 0; lane < 8; lane++) begin
            if (strobe[lane]) begin
                mask[8*lane +: 8] = 8'hff;
            end
        end
        return mask;
    endfunction

    // returns the expected response of one request and then applies its write to the model
    function automatic expect_type reference_access(
        input addr_type addr,
        input strobe_type strobe,
        input data_type wdata
    );
        expect_type result;
        addr_type word;
        data_type write_bits;
        result = '0;
        write_bits = lane_mask(strobe);
        word = addr >> 3;
        if (addr < ram_size) begin
            if (ram_known.exists(word)) begin
                result.rdata = ram_model[word];
                result.mask = ram_known[word];
            end
            ram_model[word] = (result.rdata & ~write_bits) | (wdata & write_bits);
            ram_known[word] = result.mask | write_bits;
        end else if (addr >= timer_base && addr < timer_base + timer_size) begin
            if (addr[3]) begin
                result.rdata = model_mtimecmp;
                result.mask = '1;
                model_mtimecmp = (model_mtimecmp & ~write_bits) | (wdata & write_bits);
            end else if (strobe != '0) begin
                mtime_floor = (strobe == '1) ? wdata : '0; // partial writes leave it unknown
                mtime_read = 1'b0;
            end else begin
                result.rdata = mtime_floor;
                result.is_mtime = 1'b1;
                result.rising = mtime_read;
                mtime_read = 1'b1;
            end
        end else begin
            result.error = 1'b1; // unmapped requests return zero rdata
            result.mask = '1;
        end
        return result;
    endfunction

    task automatic report_mismatch(
        input string name,
        input string relation,
        input data_type expected,
        input data_type actual
    );
        error_count++;
        $display("mismatch at %0t: %s expected %s%0h actual %0h",
                 $time, name, relation, expected, actual);
    endtask

    task automatic compare_response(input expect_type expected);
        if (mem_out.mem_error !== expected.error) begin
            report_mismatch("mem_error", "", data_type'(expected.error),
                            data_type'(mem_out.mem_error));
        end
        if (expected.is_mtime) begin
            if (mem_out.mem_rdata < expected.rdata) begin
                report_mismatch("mem_rdata", "at least ", expected.rdata, mem_out.mem_rdata);
            end
            if (expected.rising && mem_out.mem_rdata <= last_mtime) begin
                report_mismatch("mem_rdata", "above ", last_mtime, mem_out.mem_rdata);
            end
            last_mtime = mem_out.mem_rdata;
        end else if ((mem_out.mem_rdata & expected.mask) !== (expected.rdata & expected.mask)) begin
            report_mismatch("mem_rdata", "", expected.rdata & expected.mask,
                            mem_out.mem_rdata & expected.mask);
        end
    endtask

    task automatic issue(input addr_type addr, input strobe_type strobe, input data_type wdata);
        @(posedge clock);
        pending.push_back(reference_access(addr, strobe, wdata));
        mem_in <= '{mem_valid: 1'b1, mem_addr: addr, mem_wdata: wdata, mem_wstrb: strobe};
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            mem_in.mem_valid <= 1'b0;
        end
    endtask

    task automatic check_irq_low();
        @(negedge clock);
        if (timer_irq) begin
            error_count++;
            $display("timer_irq is high at %0t although mtime is below mtimecmp", $time);
        end
    endtask

    task automatic wait_irq_high(input int max_cycles);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < max_cycles && !seen; i++) begin
            @(posedge clock);
            mem_in.mem_valid <= 1'b0;
            @(negedge clock);
            seen = timer_irq;
        end
        if (!seen) begin
            error_count++;
            $display("timer_irq did not rise within %0d cycles at %0t", max_cycles, $time);
        end
    endtask

    // outputs are sampled at the falling edge, half a cycle after they change
    always @(negedge clock) begin
        if (reset) begin
            if (mem_out.mem_ready !== 1'b0) begin
                error_count++;
                $display("mem_ready is not low during reset at %0t", $time);
            end
        end else begin
            if (awaiting_ready && !mem_out.mem_ready) begin
                error_count++;
                $display("no mem_ready one cycle after the request, at %0t", $time);
            end
            if (!awaiting_ready && mem_out.mem_ready) begin
                error_count++;
                $display("mem_ready arrived at %0t with no request pending", $time);
            end
            if (awaiting_ready && pending.size() > 0) begin
                popped = pending.pop_front();
                if (mem_out.mem_ready) begin
                    compare_response(popped);
                end
            end
            awaiting_ready = mem_in.mem_valid;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles with %0d requests unanswered",
                     cycle_count, pending.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int word;
        int mode;
        strobe_type strobe;
        seed = 32'h90e3ce77;
        clock = 1'b0;
        reset = 1'b1;
        // an unmapped read stays on the bus while reset is high
        mem_in = '{mem_valid: 1'b1, mem_addr: ram_size, mem_wdata: '0, mem_wstrb: '0};
        error_count = 0;
        cycle_count = 0;
        awaiting_ready = 1'b0;
        last_mtime = '0;
        model_mtimecmp = '0;
        mtime_floor = '0;
        mtime_read = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        mem_in.mem_valid <= 1'b0;
        idle(3);

        for (word = 0; word < 8; word++) begin
            issue(addr_type'(word) << 3, 8'hff, {$random(seed), $random(seed)});
        end

        // small window of words so that reads often hit written data
        for (int i = 0; i < random_requests; i++) begin
            word = $random(seed) & 63;
            mode = $random(seed) & 3;
            case (mode)
                0: strobe = 8'h00;
                1: strobe = 8'hff;
                default: strobe = 8'($random(seed));
            endcase
            issue(addr_type'(word) << 3, strobe, {$random(seed), $random(seed)});
            if (($random(seed) & 7) == 0) begin
                idle(1);
            end
        end

        // these would alias onto words 0 to 7 if the decode ignored high bits
        for (word = 0; word < 8; word++) begin
            issue(ram_size + (addr_type'(word) << 3), 8'hff, '1);
        end
        issue(timer_base + timer_size, 8'h00, '0);
        issue(timer_base - 8, 8'hff, '1);
        issue(64'hffff_ffff_ffff_fff8, 8'h00, '0);
        issue(64'h0000_0000_8000_0000, 8'h0f, '1);
        idle(2);
        for (word = 0; word < 8; word++) begin
            issue(addr_type'(word) << 3, 8'h00, '0);
        end
        idle(2);

        issue(timer_base + 8, 8'hff, 64'h0123_4567_89ab_cdef);
        issue(timer_base + 8, 8'h0f, {$random(seed), $random(seed)});
        issue(timer_base + 8, 8'hc0, {$random(seed), $random(seed)});
        issue(timer_base + 8, 8'h24, {$random(seed), $random(seed)});
        issue(timer_base + 8, 8'h00, '0);
        idle(2);

        issue(timer_base + 8, 8'hff, '1);
        issue(timer_base, 8'hff, '0);
        idle(4);
        check_irq_low();
        issue(timer_base + 8, 8'hff, 64'd1000);
        issue(timer_base, 8'hff, 64'd2000);
        wait_irq_high(2);
        issue(timer_base, 8'h00, '0);
        issue(timer_base, 8'h00, '0);
        idle(2);

        while (pending.size() > 0) begin
            @(negedge clock);
        end
        idle(2);
        @(negedge clock);
        $display("errors: %0d, requests issued and unanswered: %0d", error_count, pending.size());
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+src
src/bus_pkg.sv
src/map_pkg.sv
src/ram.sv
src/machine_timer.sv
src/bus_router.sv
src/memory_subsystem.sv
testbench/memory_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f files.f \
    --top-module memory_subsystem_tb \
    -o memory_subsystem_sim

output=$(./obj_dir/memory_subsystem_sim)
echo "$output"
echo "$output" | grep -q ">>> PASS"
